/* src/arith_pkg.sv */
// Payload layouts are packed, and every stage that copies them keeps the field order unchanged
package arith_pkg;

  // Operand and result width
  localparam int DATA_W = 32;

  // Opcodes 6 and 7 are unused and execute to a zero value
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SHL = 3'd5
  } opcode_e;

  // Command payload, 76 bits
  typedef struct packed {
    logic              valid;
    opcode_e           opcode;
    logic [7:0]        tag;
    logic [DATA_W-1:0] opa;
    logic [DATA_W-1:0] opb;
  } cmd_t;

  // Result payload, 45 bits
  typedef struct packed {
    logic              valid;
    opcode_e           opcode;
    logic [7:0]        tag;
    logic              carry;
    logic [DATA_W-1:0] value;
  } res_t;

endpackage

/* src/wb_regs_pkg.sv */
// Word addresses only, since byte selects are not decoded and every access is a full word
package wb_regs_pkg;

  localparam int ADR_W = 4;

  // Register map
  localparam logic [ADR_W-1:0] REG_OPA      = 4'd0;
  localparam logic [ADR_W-1:0] REG_OPB      = 4'd1;
  localparam logic [ADR_W-1:0] REG_CMD      = 4'd2;
  localparam logic [ADR_W-1:0] REG_RES_DATA = 4'd3;
  // Reading this one pops the head entry
  localparam logic [ADR_W-1:0] REG_RES_INFO = 4'd4;
  localparam logic [ADR_W-1:0] REG_STATUS   = 4'd5;

endpackage

/* src/ff_slicer.sv */
// TYPE must be a packed type, and STAGES of zero turns the slicer into a plain wire
`timescale 1ns/10ps

module ff_slicer #(
  parameter int  STAGES = 1,
  parameter type TYPE   = logic
) (
  input  logic i_clk,
  input  logic i_rst_n,
  input  TYPE  i_d,
  output TYPE  o_q
);

  localparam int W = $bits(TYPE);

  if (STAGES == 0) begin : g_bypass

    assign o_q = i_d;

  end else begin : g_chain

    logic [STAGES-1:0][W-1:0] stage_q;

    // Stage 0 samples the input and the last stage drives the output
    always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        stage_q <= '0;
      end else begin
        stage_q[0] <= W'(i_d);
        for (int i = 1; i < STAGES; i++) begin
          stage_q[i] <= stage_q[i-1];
        end
      end
    end

    assign o_q = TYPE'(stage_q[STAGES-1]);

  end

endmodule

/* src/wb_cmd_decode.sv */
// Wishbone classic single cycles only; FIFO_DEPTH must stay below 256 to fit the status count
`timescale 1ns/10ps

module wb_cmd_decode
  import arith_pkg::*;
  import wb_regs_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_wb_cyc,
  input  logic              i_wb_stb,
  input  logic              i_wb_we,
  input  logic [ADR_W-1:0]  i_wb_adr,
  input  logic [DATA_W-1:0] i_wb_dat,
  output logic [DATA_W-1:0] o_wb_dat,
  output logic              o_wb_ack,
  output cmd_t              o_cmd,
  input  logic [DATA_W-1:0] i_res_data,
  input  logic [DATA_W-1:0] i_res_info,
  input  logic [7:0]        i_fill,
  input  logic              i_empty,
  output logic              o_pop
);

  localparam int CRED_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(FIFO_DEPTH);

  logic [DATA_W-1:0] opa_q;
  logic [DATA_W-1:0] opb_q;
  logic [CRED_W-1:0] credits_q;
  logic              ack_q;
  logic              pop_q;
  cmd_t              cmd_q;
  logic [DATA_W-1:0] rd_data;
  logic              access;
  logic              is_cmd_wr;
  logic              stall;
  logic              accept;
  logic              issue;
  logic              info_rd;

  // No new access in the ack cycle, the host still holds stb there
  assign access    = i_wb_cyc && i_wb_stb && !ack_q;
  assign is_cmd_wr = access && i_wb_we && (i_wb_adr == REG_CMD);
  // Every credit taken means a FIFO slot is already spoken for
  assign stall     = is_cmd_wr && (credits_q == CRED_MAX);
  assign accept    = access && !stall;
  assign issue     = is_cmd_wr && !stall;
  assign info_rd   = accept && !i_wb_we && (i_wb_adr == REG_RES_INFO) && !i_empty;

  always_comb begin
    rd_data = '0;
    case (i_wb_adr)
      REG_OPA:      rd_data = opa_q;
      REG_OPB:      rd_data = opb_q;
      REG_RES_DATA: rd_data = i_res_data;
      REG_RES_INFO: rd_data = i_empty ? '0 : i_res_info;
      REG_STATUS: begin
        rd_data[7:0] = i_fill;
        rd_data[8]   = i_empty;
      end
      default:      rd_data = '0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ack_q     <= 1'b0;
      pop_q     <= 1'b0;
      credits_q <= '0;
      opa_q     <= '0;
      opb_q     <= '0;
    end else begin
      ack_q <= accept;
      pop_q <= info_rd;
      if (accept && i_wb_we && (i_wb_adr == REG_OPA)) begin
        opa_q <= i_wb_dat;
      end
      if (accept && i_wb_we && (i_wb_adr == REG_OPB)) begin
        opb_q <= i_wb_dat;
      end
      if (issue && !pop_q) begin
        credits_q <= credits_q + 1'b1;
      end else if (pop_q && !issue) begin
        credits_q <= credits_q - 1'b1;
      end
    end
  end

  // Command register, loaded on the same edge that raises ack
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cmd_q <= '0;
    end else begin
      cmd_q.valid <= issue;
      if (issue) begin
        cmd_q.opcode <= opcode_e'(i_wb_dat[2:0]);
        cmd_q.tag    <= i_wb_dat[15:8];
        cmd_q.opa    <= opa_q;
        cmd_q.opb    <= opb_q;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept && !i_wb_we) begin
      o_wb_dat <= rd_data;
    end
  end

  assign o_wb_ack = ack_q;
  assign o_pop    = pop_q;
  assign o_cmd    = cmd_q;

  a_ack_in_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_wb_ack |-> (i_wb_cyc && i_wb_stb));

  // Stored results always hold a credit
  a_credit_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (credits_q <= CRED_MAX) && (8'(credits_q) >= i_fill));

endmodule

/* src/alu_execute.sv */
// One cycle of latency; unknown opcodes give a valid result of zero with no carry
`timescale 1ns/10ps

module alu_execute
  import arith_pkg::*;
(
  input  logic i_clk,
  input  logic i_rst_n,
  input  cmd_t i_cmd,
  output res_t o_res
);

  logic [DATA_W:0] sum_w;
  logic [DATA_W:0] diff_w;
  logic [DATA_W:0] shl_w;
  res_t            res_d;
  res_t            res_q;

  assign sum_w  = {1'b0, i_cmd.opa} + {1'b0, i_cmd.opb};
  // Top bit is the borrow
  assign diff_w = {1'b0, i_cmd.opa} - {1'b0, i_cmd.opb};
  // Top bit catches the last bit shifted out
  assign shl_w  = {1'b0, i_cmd.opa} << i_cmd.opb[4:0];

  always_comb begin
    res_d = '0;
    if (i_cmd.valid) begin
      res_d.valid  = 1'b1;
      res_d.opcode = i_cmd.opcode;
      res_d.tag    = i_cmd.tag;
      case (i_cmd.opcode)
        OP_ADD: {res_d.carry, res_d.value} = sum_w;
        OP_SUB: {res_d.carry, res_d.value} = diff_w;
        OP_AND: res_d.value = i_cmd.opa & i_cmd.opb;
        OP_OR:  res_d.value = i_cmd.opa | i_cmd.opb;
        OP_XOR: res_d.value = i_cmd.opa ^ i_cmd.opb;
        OP_SHL: {res_d.carry, res_d.value} = shl_w;
        default: res_d.value = '0;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      res_q <= '0;
    end else begin
      res_q <= res_d;
    end
  end

  assign o_res = res_q;

endmodule

/* src/result_store.sv */
// Relies on the decode credit count to never push when full; FIFO_DEPTH must stay below 256
`timescale 1ns/10ps

module result_store
  import arith_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  res_t              i_res,
  input  logic              i_pop,
  output logic [DATA_W-1:0] o_head_data,
  output logic [DATA_W-1:0] o_head_info,
  output logic [7:0]        o_fill,
  output logic              o_empty
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [7:0] FILL_MAX = 8'(FIFO_DEPTH);

  logic [DATA_W-1:0] value_mem [FIFO_DEPTH];
  logic [DATA_W-1:0] info_mem  [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [7:0]        count_q;
  logic [DATA_W-1:0] info_w;
  logic              push;
  logic              pop;
  logic              full;

  assign full = (count_q == FILL_MAX);
  assign push = i_res.valid;
  assign pop  = i_pop && !o_empty;

  // Info word with zero and sign flags taken from the value
  always_comb begin
    info_w       = '0;
    info_w[15:8] = i_res.tag;
    info_w[6:4]  = i_res.opcode;
    info_w[2]    = i_res.carry;
    info_w[1]    = (i_res.value == '0);
    info_w[0]    = i_res.value[DATA_W-1];
  end

  always_ff @(posedge i_clk) begin
    if (push) begin
      value_mem[wr_ptr_q] <= i_res.value;
      info_mem[wr_ptr_q]  <= info_w;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign o_head_data = value_mem[rd_ptr_q];
  assign o_head_info = info_mem[rd_ptr_q];
  assign o_fill      = count_q;
  assign o_empty     = (count_q == '0);

  // Credits upstream keep the result chain from overrunning the FIFO
  a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    push |-> !full);

endmodule

/* src/sliced_alu_top.sv */
// Result latency from a command ack is CMD_STAGES + RES_STAGES + 2 cycles
`timescale 1ns/10ps

module sliced_alu_top
  import arith_pkg::*;
  import wb_regs_pkg::*;
#(
  parameter int          CMD_STAGES = 2,
  parameter int          RES_STAGES = 2,
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_wb_cyc,
  input  logic              i_wb_stb,
  input  logic              i_wb_we,
  input  logic [ADR_W-1:0]  i_wb_adr,
  input  logic [DATA_W-1:0] i_wb_dat,
  output logic [DATA_W-1:0] o_wb_dat,
  output logic              o_wb_ack
);

  cmd_t              cmd_dec;
  cmd_t              cmd_exe;
  res_t              res_exe;
  res_t              res_store;
  logic [DATA_W-1:0] head_data;
  logic [DATA_W-1:0] head_info;
  logic [7:0]        fill;
  logic              empty;
  logic              pop;

  wb_cmd_decode #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_decode (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_wb_cyc   (i_wb_cyc),
    .i_wb_stb   (i_wb_stb),
    .i_wb_we    (i_wb_we),
    .i_wb_adr   (i_wb_adr),
    .i_wb_dat   (i_wb_dat),
    .o_wb_dat   (o_wb_dat),
    .o_wb_ack   (o_wb_ack),
    .o_cmd      (cmd_dec),
    .i_res_data (head_data),
    .i_res_info (head_info),
    .i_fill     (fill),
    .i_empty    (empty),
    .o_pop      (pop)
  );

  ff_slicer #(
    .STAGES (CMD_STAGES),
    .TYPE   (cmd_t)
  ) u_cmd_slicer (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_d     (cmd_dec),
    .o_q     (cmd_exe)
  );

  alu_execute u_execute (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_cmd   (cmd_exe),
    .o_res   (res_exe)
  );

  ff_slicer #(
    .STAGES (RES_STAGES),
    .TYPE   (res_t)
  ) u_res_slicer (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_d     (res_exe),
    .o_q     (res_store)
  );

  result_store #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_store (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_res       (res_store),
    .i_pop       (pop),
    .o_head_data (head_data),
    .o_head_info (head_info),
    .o_fill      (fill),
    .o_empty     (empty)
  );

endmodule

/* test/tb_sliced_alu.sv */
// Single Wishbone host with one access at a time; pipeline depths here must match the DUT setup
`timescale 1ns/10ps

module tb_sliced_alu
  import arith_pkg::*;
  import wb_regs_pkg::*;
();

  localparam int CMD_STAGES  = 2;
  localparam int RES_STAGES  = 2;
  localparam int FIFO_DEPTH  = 4;
  localparam int LATENCY     = CMD_STAGES + RES_STAGES + 2;
  localparam int RAND_OPS    = 200;
  // Random ops plus ordering, back-pressure and edge cases
  localparam int TOTAL_OPS   = RAND_OPS + 2 * FIFO_DEPTH + 1 + 3;
  localparam int OP_BOUND_NS = 400;
  localparam int WAIT_LIMIT  = 64;

  logic              clk;
  logic              rst_n;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [ADR_W-1:0]  wb_adr;
  logic [DATA_W-1:0] wb_dat_w;
  logic [DATA_W-1:0] wb_dat_r;
  logic              wb_ack;
  integer            seed;
  logic [DATA_W-1:0] exp_value_q [$];
  logic [DATA_W-1:0] exp_info_q  [$];

  sliced_alu_top #(
    .CMD_STAGES (CMD_STAGES),
    .RES_STAGES (RES_STAGES),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut0 (
    .i_clk    (clk),
    .i_rst_n  (rst_n),
    .i_wb_cyc (wb_cyc),
    .i_wb_stb (wb_stb),
    .i_wb_we  (wb_we),
    .i_wb_adr (wb_adr),
    .i_wb_dat (wb_dat_w),
    .o_wb_dat (wb_dat_r),
    .o_wb_ack (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(TOTAL_OPS * OP_BOUND_NS);
    $display("Watchdog expired before the tests completed");
    $display("Something failed");
    $fatal(1, "run stopped by watchdog");
  end

  task automatic check(input string name, input logic [DATA_W-1:0] got,
                       input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("Something failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "run aborted");
  endtask

  // Expected {carry, value} straight from the opcode rules
  function automatic logic [DATA_W:0] model_result(input logic [2:0] op,
                                                   input logic [DATA_W-1:0] a,
                                                   input logic [DATA_W-1:0] b);
    logic [DATA_W:0] r;
    int              sh;
    r  = '0;
    sh = int'(b[4:0]);
    case (op)
      OP_ADD: r = {(a + b) < a, a + b};
      OP_SUB: r = {(a < b), a - b};
      OP_AND: r[DATA_W-1:0] = a & b;
      OP_OR:  r[DATA_W-1:0] = a | b;
      OP_XOR: r[DATA_W-1:0] = a ^ b;
      OP_SHL: r = {(sh != 0) ? a[DATA_W - sh] : 1'b0, a << sh};
      default: r = '0;
    endcase
    return r;
  endfunction

  task automatic wait_ack();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_ack && n < WAIT_LIMIT);
    if (!wb_ack) abort_run("No Wishbone ack within the cycle limit");
  endtask

  // The bus is held through the ack cycle and released on the next falling edge
  task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [DATA_W-1:0] dat);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = dat;
    wait_ack();
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [DATA_W-1:0] dat);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_ack();
    dat    = wb_dat_r;
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic expect_result(input logic [2:0] op, input logic [7:0] tag,
                               input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
    logic [DATA_W:0] r;
    r = model_result(op, a, b);
    exp_value_q.push_back(r[DATA_W-1:0]);
    exp_info_q.push_back({16'h0, tag, 1'b0, op, 1'b0, r[DATA_W],
                          (r[DATA_W-1:0] == '0), r[DATA_W-1]});
  endtask

  task automatic issue_op(input logic [2:0] op, input logic [7:0] tag,
                          input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
    wb_write(REG_OPA, a);
    wb_write(REG_OPB, b);
    wb_write(REG_CMD, {16'h0, tag, 5'h0, op});
    expect_result(op, tag, a, b);
  endtask

  task automatic issue_random();
    logic [2:0] op;
    op = 3'($unsigned($random(seed)) % 6);
    issue_op(op, 8'($random(seed)), $random(seed), $random(seed));
  endtask

  task automatic pop_check();
    logic [DATA_W-1:0] rd;
    if (exp_value_q.size() == 0) abort_run("Result read with an empty model queue");
    wb_read(REG_RES_DATA, rd);
    check("res_data", rd, exp_value_q.pop_front());
    wb_read(REG_RES_INFO, rd);
    check("res_info", rd, exp_info_q.pop_front());
  endtask

  task automatic check_status(input int count);
    logic [DATA_W-1:0] rd;
    wb_read(REG_STATUS, rd);
    check("status", rd, {23'h0, (count == 0), 8'(count)});
  endtask

  task automatic wait_fill(input int count);
    logic [DATA_W-1:0] rd;
    int                n;
    n = 0;
    do begin
      wb_read(REG_STATUS, rd);
      n++;
    end while (rd[7:0] != 8'(count) && n < WAIT_LIMIT);
    if (rd[7:0] != 8'(count)) abort_run("FIFO count never reached the expected value");
    check("status", rd, {23'h0, (count == 0), 8'(count)});
  endtask

  initial begin
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] rd;
    seed     = 32'h406382e3;
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    check_status(0);
    wb_read(REG_RES_INFO, rd);
    check("res_info", rd, '0);

    a = $random(seed);
    b = $random(seed);
    wb_write(REG_OPA, a);
    wb_write(REG_OPB, b);
    wb_read(REG_OPA, rd);
    check("opa", rd, a);
    wb_read(REG_OPB, rd);
    check("opb", rd, b);

    for (int i = 0; i < RAND_OPS; i++) begin
      issue_random();
      wait_fill(1);
      pop_check();
    end

    // Burst without reads drains in issue order
    for (int i = 0; i < FIFO_DEPTH; i++) issue_random();
    wait_fill(FIFO_DEPTH);
    for (int i = FIFO_DEPTH; i > 0; i--) begin
      check_status(i);
      pop_check();
    end
    check_status(0);

    // All credits taken, so the next command write has to stall
    for (int i = 0; i < FIFO_DEPTH; i++) issue_random();
    wait_fill(FIFO_DEPTH);
    a = $random(seed);
    b = $random(seed);
    wb_write(REG_OPA, a);
    wb_write(REG_OPB, b);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = REG_CMD;
    wb_dat_w = {16'h0, 8'h5a, 5'h0, OP_XOR};
    repeat (3 * LATENCY) begin
      @(negedge clk);
      check("o_wb_ack", {31'h0, wb_ack}, '0);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    pop_check();
    wb_write(REG_CMD, {16'h0, 8'h5a, 5'h0, OP_XOR});
    expect_result(OP_XOR, 8'h5a, a, b);
    wait_fill(FIFO_DEPTH);
    for (int i = 0; i < FIFO_DEPTH; i++) pop_check();
    check_status(0);

    // Edge operands for carry, borrow, zero, sign and a full shift
    issue_op(OP_ADD, 8'hc1, 32'hffff_ffff, 32'h1);
    wait_fill(1);
    pop_check();
    issue_op(OP_SUB, 8'hc2, 32'h0, 32'h1);
    wait_fill(1);
    pop_check();
    issue_op(OP_SHL, 8'hc3, 32'h3, 32'd31);
    wait_fill(1);
    pop_check();

    $display("Everything OK");
    $finish;
  end

endmodule

/* sliced_alu_top.f */
src/arith_pkg.sv
src/wb_regs_pkg.sv
src/ff_slicer.sv
src/wb_cmd_decode.sv
src/alu_execute.sv
src/result_store.sv
src/sliced_alu_top.sv
test/tb_sliced_alu.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_sliced_alu -f sliced_alu_top.f \
  --Mdir obj_dir -o tb_sliced_alu > sim.log 2>&1 \
  && ./obj_dir/tb_sliced_alu >> sim.log 2>&1 \
  || echo "Something failed" >> sim.log
grep -q "Something failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Everything OK" sim.log && { echo "PASS"; exit 0; }
echo "FAIL, no result in sim.log"
exit 1
